// ==== Makefile ====
# Verilator build for the panel command decoder testbench

TOP = panel_ctrl_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim.f ====
+incdir+tests
source/panel_pkg.sv
source/display_op_if.sv
source/cmd_parser.sv
source/op_fifo.sv
source/ram_sequencer.sv
source/panel_ctrl_top.sv
tests/panel_ctrl_tb.sv

// ==== source/cmd_parser.sv ====
// Byte-level command decoder. Applies channel and brightness commands at once
// and turns pixel, fill and blank commands into display operations.
`timescale 1ns/1ps

module cmd_parser import panel_pkg::*; (
    input logic clk_in,
    input logic reset,
    input byte_t data_rx,
    input logic data_ready_n,
    output logic ready_for_data,
    output rgb_t rgb_enable,
    output brightness_t brightness_enable,
    output logic parsing,
    display_op_if.sender op
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_BRIGHT_ARG,
        S_PIX_ROW,
        S_PIX_COL,
        S_PIX_HIGH,
        S_PIX_LOW,
        S_FILL_HIGH,
        S_FILL_LOW,
        S_PUSH
    } parser_state_t;

    parser_state_t state;
    row_t row_q;
    col_t col_q;
    colour_t colour_q;
    op_kind_t kind_q;
    logic byte_take;
    byte_t toggle_k;

    // source holds its byte while we wait for the FIFO
    assign ready_for_data = (state != S_PUSH);
    assign byte_take = ~data_ready_n && ready_for_data;
    assign parsing = (state != S_IDLE);

    // offset into the "1".."6" range, wraps high for bytes below it
    assign toggle_k = data_rx - CMD_BRIGHT_TOGGLE_FIRST;

    assign op.valid = (state == S_PUSH);
    assign op.kind = kind_q;
    assign op.addr = {row_q, col_q};
    assign op.colour = colour_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= S_IDLE;
            rgb_enable <= '1;
            brightness_enable <= '1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (byte_take) begin
                        case (data_rx)
                            CMD_RED_ON: rgb_enable[0] <= 1'b1;
                            CMD_RED_OFF: rgb_enable[0] <= 1'b0;
                            CMD_GREEN_ON: rgb_enable[1] <= 1'b1;
                            CMD_GREEN_OFF: rgb_enable[1] <= 1'b0;
                            CMD_BLUE_ON: rgb_enable[2] <= 1'b1;
                            CMD_BLUE_OFF: rgb_enable[2] <= 1'b0;
                            CMD_BRIGHT_CLEAR: brightness_enable <= '0;
                            CMD_BRIGHT_FULL: brightness_enable <= '1;
                            CMD_BRIGHT_SET: state <= S_BRIGHT_ARG;
                            CMD_PIXEL: state <= S_PIX_ROW;
                            CMD_FILL: state <= S_FILL_HIGH;
                            CMD_BLANK: begin
                                kind_q <= OP_FILL;
                                colour_q <= '0;
                                state <= S_PUSH;
                            end
                            default: begin
                                // anything else outside the toggle range is dropped
                                if (toggle_k < BRIGHTNESS_LEVELS) begin
                                    brightness_enable[BRIGHTNESS_LEVELS - 1 - int'(toggle_k)] <=
                                        ~brightness_enable[BRIGHTNESS_LEVELS - 1 - int'(toggle_k)];
                                end
                            end
                        endcase
                    end
                end
                S_BRIGHT_ARG: begin
                    if (byte_take) begin
                        brightness_enable <= data_rx[BRIGHTNESS_LEVELS-1:0];
                        state <= S_IDLE;
                    end
                end
                S_PIX_ROW: begin
                    if (byte_take) begin
                        row_q <= data_rx[ROW_BITS-1:0];
                        state <= S_PIX_COL;
                    end
                end
                S_PIX_COL: begin
                    if (byte_take) begin
                        col_q <= data_rx[COL_BITS-1:0];
                        state <= S_PIX_HIGH;
                    end
                end
                S_PIX_HIGH: begin
                    if (byte_take) begin
                        colour_q[15:8] <= data_rx;
                        state <= S_PIX_LOW;
                    end
                end
                S_PIX_LOW: begin
                    if (byte_take) begin
                        colour_q[7:0] <= data_rx;
                        kind_q <= OP_PIXEL;
                        state <= S_PUSH;
                    end
                end
                S_FILL_HIGH: begin
                    if (byte_take) begin
                        colour_q[15:8] <= data_rx;
                        state <= S_FILL_LOW;
                    end
                end
                S_FILL_LOW: begin
                    if (byte_take) begin
                        colour_q[7:0] <= data_rx;
                        kind_q <= OP_FILL;
                        state <= S_PUSH;
                    end
                end
                S_PUSH: begin
                    if (op.ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== source/display_op_if.sv ====
// One display operation with a valid/ready handshake. Used between the
// parser and the FIFO, and between the FIFO and the RAM sequencer.
`timescale 1ns/1ps

interface display_op_if import panel_pkg::*; ();

    logic valid;
    logic ready;
    op_kind_t kind;
    pixel_addr_t addr;
    colour_t colour;

    modport sender (
        output valid,
        output kind,
        output addr,
        output colour,
        input ready
    );

    modport receiver (
        input valid,
        input kind,
        input addr,
        input colour,
        output ready
    );

endinterface

// ==== source/op_fifo.sv ====
// Small circular FIFO of display operations between parser and sequencer.
// Full stalls the parser, empty keeps the sequencer idle.
`timescale 1ns/1ps

module op_fifo import panel_pkg::*; (
    input logic clk_in,
    input logic reset,
    display_op_if.receiver op_in,
    display_op_if.sender op_out,
    output logic not_empty
);

    op_kind_t kind_mem [OP_FIFO_DEPTH];
    pixel_addr_t addr_mem [OP_FIFO_DEPTH];
    colour_t colour_mem [OP_FIFO_DEPTH];

    logic [$clog2(OP_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(OP_FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(OP_FIFO_DEPTH+1)-1:0] count;
    logic push;
    logic pop;

    assign op_in.ready = (count != OP_FIFO_DEPTH);
    assign op_out.valid = (count != 0);
    assign not_empty = op_out.valid;

    assign push = op_in.valid && op_in.ready;
    assign pop = op_out.valid && op_out.ready;

    assign op_out.kind = kind_mem[rd_ptr];
    assign op_out.addr = addr_mem[rd_ptr];
    assign op_out.colour = colour_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (push) begin
            kind_mem[wr_ptr] <= op_in.kind;
            addr_mem[wr_ptr] <= op_in.addr;
            colour_mem[wr_ptr] <= op_in.colour;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == OP_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == OP_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== source/panel_ctrl_top.sv ====
// Top level of the panel command decoder: parser, operation FIFO and RAM
// sequencer in a chain. busy stays high until the last RAM write is done.
`timescale 1ns/1ps

module panel_ctrl_top import panel_pkg::*; (
    input logic clk_in,
    input logic reset,
    input byte_t data_rx,
    input logic data_ready_n,
    output logic ready_for_data,
    output logic busy,
    output rgb_t rgb_enable,
    output brightness_t brightness_enable,
    output ram_addr_t ram_address,
    output byte_t ram_data_out,
    output logic ram_write_enable
);

    logic parsing;
    logic fifo_not_empty;
    logic seq_active;

    display_op_if op_in ();
    display_op_if op_out ();

    cmd_parser u_parser (
        .clk_in(clk_in),
        .reset(reset),
        .data_rx(data_rx),
        .data_ready_n(data_ready_n),
        .ready_for_data(ready_for_data),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .parsing(parsing),
        .op(op_in.sender)
    );

    op_fifo u_fifo (
        .clk_in(clk_in),
        .reset(reset),
        .op_in(op_in.receiver),
        .op_out(op_out.sender),
        .not_empty(fifo_not_empty)
    );

    ram_sequencer u_sequencer (
        .clk_in(clk_in),
        .reset(reset),
        .op(op_out.receiver),
        .ram_address(ram_address),
        .ram_data_out(ram_data_out),
        .ram_write_enable(ram_write_enable),
        .active(seq_active)
    );

    assign busy = parsing || fifo_not_empty || seq_active;

endmodule

// ==== source/panel_pkg.sv ====
// Shared geometry, widths, types and command byte values for the LED panel
// command decoder. Imported by every design file and by the testbench.
package panel_pkg;

    localparam int ROW_BITS = 3;
    localparam int COL_BITS = 4;
    localparam int BRIGHTNESS_LEVELS = 6;
    localparam int OP_FIFO_DEPTH = 4;

    typedef logic [7:0] byte_t;
    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [COL_BITS-1:0] col_t;
    typedef logic [ROW_BITS+COL_BITS-1:0] pixel_addr_t;
    // pixel address then inverted byte select, high byte lands on the odd address
    typedef logic [ROW_BITS+COL_BITS:0] ram_addr_t;
    typedef logic [15:0] colour_t;
    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;
    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_t;

    typedef enum logic {
        OP_PIXEL,
        OP_FILL
    } op_kind_t;

    localparam byte_t CMD_RED_ON = "R";
    localparam byte_t CMD_RED_OFF = "r";
    localparam byte_t CMD_GREEN_ON = "G";
    localparam byte_t CMD_GREEN_OFF = "g";
    localparam byte_t CMD_BLUE_ON = "B";
    localparam byte_t CMD_BLUE_OFF = "b";
    localparam byte_t CMD_BRIGHT_CLEAR = "0";
    localparam byte_t CMD_BRIGHT_FULL = "9";
    localparam byte_t CMD_BRIGHT_SET = "T";
    localparam byte_t CMD_PIXEL = "P";
    localparam byte_t CMD_FILL = "F";
    localparam byte_t CMD_BLANK = "Z";
    // "1"+k toggles brightness bit BRIGHTNESS_LEVELS-1-k
    localparam byte_t CMD_BRIGHT_TOGGLE_FIRST = "1";

endpackage

// ==== source/ram_sequencer.sv ====
// Runs display operations against the frame RAM, one byte write per cycle.
// A pixel is two writes, a fill sweeps every pixel address in order.
`timescale 1ns/1ps

module ram_sequencer import panel_pkg::*; (
    input logic clk_in,
    input logic reset,
    display_op_if.receiver op,
    output ram_addr_t ram_address,
    output byte_t ram_data_out,
    output logic ram_write_enable,
    output logic active
);

    logic running;
    op_kind_t kind_q;
    colour_t colour_q;
    pixel_addr_t pix_addr;
    // 0 selects the high byte, which goes out first
    logic byte_sel;

    assign op.ready = ~running;

    // include the last registered strobe so busy covers it
    assign active = running || ram_write_enable;

    always_ff @(posedge clk_in) begin
        if (!running && op.valid) begin
            kind_q <= op.kind;
            colour_q <= op.colour;
            pix_addr <= (op.kind == OP_FILL) ? '0 : op.addr;
            byte_sel <= 1'b0;
        end else if (running) begin
            ram_address <= {pix_addr, ~byte_sel};
            ram_data_out <= byte_sel ? colour_q[7:0] : colour_q[15:8];
            byte_sel <= ~byte_sel;
            if (byte_sel && kind_q == OP_FILL) begin
                pix_addr <= pix_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            running <= 1'b0;
            ram_write_enable <= 1'b0;
        end else begin
            ram_write_enable <= running;
            if (!running && op.valid) begin
                running <= 1'b1;
            end else if (running && byte_sel) begin
                // low byte just went out
                if (kind_q == OP_PIXEL || pix_addr == '1) begin
                    running <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== tests/panel_ctrl_tests.svh ====
// Directed tests for the panel command decoder, included in the testbench top.
// Every task starts and ends 1 ns after a rising clock edge.

task automatic send_setting(input byte_t b);
    send_byte(b);
    apply_setting(b);
    check_rgb("rgb_enable", rgb_enable, model_rgb);
    check_brightness("brightness_enable", brightness_enable, model_bright);
endtask

task automatic send_pixel(input byte_t row_b, input byte_t col_b, input colour_t c);
    send_byte(CMD_PIXEL);
    send_byte(row_b);
    send_byte(col_b);
    send_byte(c[15:8]);
    send_byte(c[7:0]);
    expect_pixel(row_t'(row_b), col_t'(col_b), c);
endtask

task automatic send_fill(input colour_t c);
    send_byte(CMD_FILL);
    send_byte(c[15:8]);
    send_byte(c[7:0]);
    expect_fill(c);
endtask

task automatic send_random_pixel();
    byte_t row_b;
    byte_t col_b;
    colour_t c;
    row_b = random_byte();
    col_b = random_byte();
    c[15:8] = random_byte();
    c[7:0] = random_byte();
    send_pixel(row_b, col_b, c);
endtask

task automatic reset_defaults();
    int errors_before;
    errors_before = error_count;
    check_rgb("rgb_enable", rgb_enable, '1);
    check_brightness("brightness_enable", brightness_enable, '1);
    check_flag("busy", busy, 1'b0);
    check_flag("ready_for_data", ready_for_data, 1'b1);
    repeat (3) begin
        check_flag("ram_write_enable", ram_write_enable, 1'b0);
        @(posedge clk_in);
        #1;
    end
    compare_ram();
    report_test("reset_defaults", errors_before);
endtask

task automatic channel_and_brightness();
    string seq;
    int errors_before;
    errors_before = error_count;
    // x, /, 7, 8, A, q and the raw bytes below are not commands
    seq = "rgb135R/G2x79B4g0A6r5b8Gq6";
    for (int i = 0; i < seq.len(); i++) begin
        send_setting(byte_t'(seq[i]));
    end
    send_setting(8'h00);
    send_setting(8'hff);
    send_setting(CMD_BRIGHT_FULL);
    report_test("channel_and_brightness", errors_before);
endtask

task automatic brightness_from_argument();
    byte_t arg;
    int errors_before;
    errors_before = error_count;
    for (int n = 0; n < 8; n++) begin
        arg = random_byte();
        send_byte(CMD_BRIGHT_SET);
        check_flag("busy", busy, 1'b1);
        send_byte(arg);
        model_bright = arg[BRIGHTNESS_LEVELS-1:0];
        check_brightness("brightness_enable", brightness_enable, model_bright);
        check_rgb("rgb_enable", rgb_enable, model_rgb);
    end
    report_test("brightness_from_argument", errors_before);
endtask

task automatic pixel_writes();
    int errors_before;
    errors_before = error_count;
    longest_stall = 0;
    // the blank keeps the sequencer busy so the pixels back up in the FIFO
    send_byte(CMD_BLANK);
    expect_fill('0);
    for (int n = 0; n < 6; n++) begin
        send_random_pixel();
    end
    // a push alone costs one cycle, a full FIFO holds the source longer
    check_flag("ready_for_data stalled", longest_stall > 1, 1'b1);
    wait_idle();
    compare_ram();
    report_test("pixel_writes", errors_before);
endtask

task automatic fill_and_blank();
    colour_t c;
    int errors_before;
    errors_before = error_count;
    c[15:8] = random_byte();
    c[7:0] = random_byte();
    send_fill(c);
    wait_idle();
    compare_ram();
    send_byte(CMD_BLANK);
    expect_fill('0);
    wait_idle();
    compare_ram();
    report_test("fill_and_blank", errors_before);
endtask

task automatic pixels_over_fill();
    colour_t c;
    int errors_before;
    errors_before = error_count;
    c[15:8] = random_byte();
    c[7:0] = random_byte();
    send_fill(c);
    for (int n = 0; n < 4; n++) begin
        send_random_pixel();
    end
    // fill still sweeping while the pixels wait behind it
    check_flag("busy", busy, 1'b1);
    wait_idle();
    compare_ram();
    report_test("pixels_over_fill", errors_before);
endtask

// ==== tests/panel_ctrl_tb.sv ====
// Testbench top for the LED panel command decoder. Holds clock, reset, the DUT,
// a frame RAM model, the expected-value models and the compare tasks.
`timescale 1ns/1ps

module panel_ctrl_tb import panel_pkg::*; ();

    localparam int CLK_PERIOD_NS = 4;
    localparam int FILL_CYCLES = 6 * 256;
    localparam int BYTE_CYCLES = 300;
    localparam int WATCHDOG_NS = 2 * (FILL_CYCLES + BYTE_CYCLES) * CLK_PERIOD_NS;
    localparam int STALL_LIMIT = 600;
    localparam int IDLE_LIMIT = 600;
    localparam logic [15:0] LFSR_SEED = 16'd99;

    logic clk_in;
    logic reset;
    byte_t data_rx;
    logic data_ready_n;
    logic ready_for_data;
    logic busy;
    rgb_t rgb_enable;
    brightness_t brightness_enable;
    ram_addr_t ram_address;
    byte_t ram_data_out;
    logic ram_write_enable;

    byte_t ram_model [256];
    byte_t exp_ram [256];
    rgb_t model_rgb;
    brightness_t model_bright;
    logic [15:0] lfsr_state;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int longest_stall = 0;

    panel_ctrl_top u_dut (
        .clk_in(clk_in),
        .reset(reset),
        .data_rx(data_rx),
        .data_ready_n(data_ready_n),
        .ready_for_data(ready_for_data),
        .busy(busy),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .ram_address(ram_address),
        .ram_data_out(ram_data_out),
        .ram_write_enable(ram_write_enable)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_in = ~clk_in;
    end

    function automatic byte_t fill_pattern(input int a);
        return byte_t'(a * 7) ^ 8'h5a;
    endfunction

    // frame RAM, preloaded with the address pattern while reset is high
    always @(posedge clk_in) begin
        if (reset) begin
            for (int a = 0; a < 256; a++) begin
                ram_model[a] <= fill_pattern(a);
            end
        end else if (ram_write_enable) begin
            ram_model[ram_address] <= ram_data_out;
        end
    end

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    function automatic byte_t random_byte();
        byte_t b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return b;
    endfunction

    // reference rules for the single-byte setting commands
    function automatic void apply_setting(input byte_t b);
        int k;
        k = int'(b) - int'(CMD_BRIGHT_TOGGLE_FIRST);
        case (b)
            CMD_RED_ON: model_rgb[0] = 1'b1;
            CMD_RED_OFF: model_rgb[0] = 1'b0;
            CMD_GREEN_ON: model_rgb[1] = 1'b1;
            CMD_GREEN_OFF: model_rgb[1] = 1'b0;
            CMD_BLUE_ON: model_rgb[2] = 1'b1;
            CMD_BLUE_OFF: model_rgb[2] = 1'b0;
            CMD_BRIGHT_CLEAR: model_bright = '0;
            CMD_BRIGHT_FULL: model_bright = '1;
            default: begin
                if (k >= 0 && k < BRIGHTNESS_LEVELS) begin
                    model_bright[BRIGHTNESS_LEVELS - 1 - k] =
                        ~model_bright[BRIGHTNESS_LEVELS - 1 - k];
                end
            end
        endcase
    endfunction

    // high byte on the odd address, low byte on the even one
    function automatic void expect_pixel(input row_t row, input col_t col, input colour_t c);
        exp_ram[{row, col, 1'b1}] = c[15:8];
        exp_ram[{row, col, 1'b0}] = c[7:0];
    endfunction

    function automatic void expect_fill(input colour_t c);
        for (int a = 0; a < 256; a++) begin
            exp_ram[a] = a[0] ? c[15:8] : c[7:0];
        end
    endfunction

    task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s got 0x%h expected 0x%h", $time, name, actual, expected);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_brightness(input string name, input brightness_t actual,
                                    input brightness_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic compare_ram();
        for (int a = 0; a < 256; a++) begin
            check_byte($sformatf("ram[%0d]", a), ram_model[a], exp_ram[a]);
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the edge that took the byte
    task automatic send_byte(input byte_t b);
        int waited;
        waited = 0;
        data_rx = b;
        data_ready_n = 1'b0;
        while (!ready_for_data && waited < STALL_LIMIT) begin
            @(posedge clk_in);
            #1;
            waited++;
        end
        if (waited > longest_stall) begin
            longest_stall = waited;
        end
        if (!ready_for_data) begin
            error_count++;
            $display("byte 0x%h was never taken, ready_for_data stayed low", b);
        end else begin
            @(posedge clk_in);
            #1;
        end
        data_ready_n = 1'b1;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_LIMIT) begin
            @(posedge clk_in);
            #1;
            cycles++;
        end
        if (busy) begin
            error_count++;
            $display("busy still high after %0d cycles, the DUT never went idle", IDLE_LIMIT);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    `include "panel_ctrl_tests.svh"

    initial begin
        data_rx = '0;
        data_ready_n = 1'b1;
        reset = 1'b1;
        lfsr_state = LFSR_SEED;
        model_rgb = '1;
        model_bright = '1;
        for (int a = 0; a < 256; a++) begin
            exp_ram[a] = fill_pattern(a);
        end
        repeat (2) @(posedge clk_in);
        #1;
        reset = 1'b0;

        reset_defaults();
        channel_and_brightness();
        brightness_from_argument();
        pixel_writes();
        fill_and_blank();
        pixels_over_fill();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
